//--- Makefile
# Verilator build and run for the SMC testbench
TOP := tb_smc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

//--- source/smc_apb_if.sv
// APB-lite slave for the SMC: access-phase decode into register write strobes, read mux
`timescale 1ns/1ps

module smc_apb_if
  import smc_pkg::*;
(
  input  logic                  pclk,        // Only clocks the checks below
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0]     pwdata,
  input  cfg_word_u             timing_q,    // Stored timing word
  input  cfg_word_u             cs_ctrl_q,   // Stored chip-select word
  output logic [DATA_W-1:0]     prdata,
  output logic                  wr_timing,   // One-cycle write strobe
  output logic                  wr_cs_ctrl,  // One-cycle write strobe
  output logic [DATA_W-1:0]     wr_data
);

  logic access_wr;  // Write in access phase

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  // Two-cycle transfer, no wait states, so access phase is one cycle
  assign access_wr = psel & penable & pwrite;

  always_comb
  begin
    wr_timing  = 1'b0;
    wr_cs_ctrl = 1'b0;
    if (access_wr)
    begin
      case (paddr)
        REG_TIMING:  wr_timing  = 1'b1;
        REG_CS_CTRL: wr_cs_ctrl = 1'b1;
        default:     ;                   // Unmapped, dropped
      endcase
    end
  end

  assign wr_data = pwdata;  // Regs pick their own fields

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  // Address only, not qualified by psel
  always_comb
  begin
    case (paddr)
      REG_TIMING:  prdata = timing_q;
      REG_CS_CTRL: prdata = cs_ctrl_q;
      default:     prdata = '0;         // Hole in map reads zero
    endcase
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // One register per access phase
  a_one_strobe: assert property (
    @(posedge pclk) disable iff (!rst_n)
    !(wr_timing && wr_cs_ctrl)
  );

  // A strobe only ever ends an APB write transfer started a cycle before
  a_strobe_after_setup: assert property (
    @(posedge pclk) disable iff (!rst_n)
    (wr_timing || wr_cs_ctrl) |-> $past(psel && !penable && pwrite)
  );

endmodule

//--- source/smc_cfg_regs.sv
// SMC configuration registers: timing counts and bank enables, loaded from the APB slave
`timescale 1ns/1ps

module smc_cfg_regs
  import smc_pkg::*;
#(
  parameter int NUM_CS = 4  // Banks present, 2 or 4
)
(
  input  logic              pclk,
  input  logic              rst_n,
  input  logic              wr_timing,
  input  logic              wr_cs_ctrl,
  input  logic [DATA_W-1:0] wr_data,
  output cfg_word_u         timing_q,
  output cfg_word_u         cs_ctrl_q
);

  // Enables above NUM_CS never stick
  localparam logic [3:0] EN_MASK = 4'((1 << NUM_CS) - 1);

  cfg_word_u wr_word;  // Incoming word, seen through either view

  assign wr_word = wr_data;

  // --------------------------------------------------
  // Timing register
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      timing_q <= TIMING_RST;
    end
    else if (wr_timing)
    begin
      timing_q.tm.setup   <= wr_word.tm.setup;
      timing_q.tm.rd_wait <= wr_word.tm.rd_wait;
      timing_q.tm.wr_wait <= wr_word.tm.wr_wait;
      timing_q.tm.hold    <= wr_word.tm.hold;
      timing_q.tm.rsvd    <= '0;              // Reads back as zero
    end
  end

  // --------------------------------------------------
  // Chip-select register
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      cs_ctrl_q <= CS_CTRL_RST & 32'(EN_MASK);  // Only banks that exist
    end
    else if (wr_cs_ctrl)
    begin
      cs_ctrl_q.cs.en   <= wr_word.cs.en & EN_MASK;
      cs_ctrl_q.cs.rsvd <= '0;
    end
  end

endmodule

//--- source/smc_pkg.sv
// SMC shared definitions: APB register map, configuration word layout and reset values
package smc_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int APB_ADDR_W = 5;   // APB byte address
  localparam int DATA_W     = 32;  // APB, host and memory data

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [APB_ADDR_W-1:0] REG_TIMING  = 5'h00;  // Setup/wait/hold counts
  localparam logic [APB_ADDR_W-1:0] REG_CS_CTRL = 5'h04;  // Bank enables

  // --------------------------------------------------
  // Configuration word
  // --------------------------------------------------
  // Same 32 bits, decoded by register address
  typedef union packed {
    // Timing register view, LSB first: setup, rd wait, wr wait, hold
    struct packed {
      logic [19:0] rsvd;     // Stored as zero
      logic [1:0]  hold;     // Cycles with cs low, strobes high
      logic [3:0]  wr_wait;  // we_n low for wr_wait+1
      logic [3:0]  rd_wait;  // oe_n low for rd_wait+1
      logic [1:0]  setup;    // Cycles of cs low before strobe
    } tm;
    // Chip-select register view
    struct packed {
      logic [27:0] rsvd;     // Stored as zero
      logic [3:0]  en;       // One enable per bank
    } cs;
  } cfg_word_u;

  // --------------------------------------------------
  // Reset values
  // --------------------------------------------------
  // hold 1 | wr_wait 1 | rd_wait 2 | setup 1
  localparam cfg_word_u TIMING_RST  = 32'h0000_0449;
  localparam cfg_word_u CS_CTRL_RST = 32'h0000_000f;  // All four banks on

endpackage

//--- source/smc_req_stage.sv
// SMC request stage: four-phase host handshake feeding a one-entry request buffer
`timescale 1ns/1ps

module smc_req_stage
  import smc_pkg::*;
#(
  parameter int ADDR_W = 16
)
(
  input  logic              pclk,
  input  logic              rst_n,
  input  logic              host_req,
  input  logic              host_we,
  input  logic [ADDR_W-1:0] host_addr,
  input  logic [DATA_W-1:0] host_wdata,
  input  logic              req_ready,   // Timing stage idle
  output logic              host_ack,
  output logic              req_valid,
  output logic              req_we,
  output logic [ADDR_W-1:0] req_addr,
  output logic [DATA_W-1:0] req_wdata
);

  // Handshake states
  localparam logic WAIT_REQ  = 1'b0;  // ack low, watching req
  localparam logic WAIT_DROP = 1'b1;  // ack high, waiting for req low

  logic              hs_state;
  logic              buf_valid;  // Entry held for timing stage
  logic              buf_we;
  logic [ADDR_W-1:0] buf_addr;
  logic [DATA_W-1:0] buf_wdata;
  logic              accept;     // Capture this cycle
  logic              taken;      // Handed to timing stage

  assign accept = (hs_state == WAIT_REQ) && host_req && !buf_valid;  // Full buffer holds ack
  assign taken  = buf_valid && req_ready;

  // --------------------------------------------------
  // Four-phase FSM and buffer valid
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      hs_state  <= WAIT_REQ;
      buf_valid <= 1'b0;
    end
    else
    begin
      case (hs_state)
        WAIT_REQ:  if (accept) hs_state <= WAIT_DROP;
        WAIT_DROP: if (!host_req) hs_state <= WAIT_REQ;   // ack falls next cycle
        default:   hs_state <= WAIT_REQ;
      endcase
      if (accept)
        buf_valid <= 1'b1;
      else if (taken)
        buf_valid <= 1'b0;
    end
  end

  // Request payload
  always_ff @(posedge pclk)
  begin
    if (accept)
    begin
      buf_we    <= host_we;
      buf_addr  <= host_addr;
      buf_wdata <= host_wdata;
    end
  end

  assign host_ack  = (hs_state == WAIT_DROP);
  assign req_valid = buf_valid;
  assign req_we    = buf_we;
  assign req_addr  = buf_addr;
  assign req_wdata = buf_wdata;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_no_ack_when_full: assert property (
    @(posedge pclk) disable iff (!rst_n)
    $rose(host_ack) |-> !$past(buf_valid)
  );

  // Stalled request holds still until the timing stage takes it
  a_hold_when_stalled: assert property (
    @(posedge pclk) disable iff (!rst_n)
    (req_valid && !req_ready) |=> req_valid && $stable({req_we, req_addr, req_wdata})
  );

endmodule

//--- source/smc_timing_stage.sv
// SMC timing stage: bank decode, setup/strobe/hold sequencing of SRAM strobes, read return
`timescale 1ns/1ps

module smc_timing_stage
  import smc_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int NUM_CS = 4
)
(
  input  logic              pclk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  logic              req_we,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  input  cfg_word_u         timing_q,
  input  cfg_word_u         cs_ctrl_q,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              req_ready,
  output logic [NUM_CS-1:0] mem_cs_n,
  output logic              mem_oe_n,
  output logic              mem_we_n,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  output logic              rd_valid,
  output logic [DATA_W-1:0] rd_data
);

  localparam int CS_W = $clog2(NUM_CS);  // Bank index bits, top of address

  // Phases
  localparam logic [1:0] PH_IDLE   = 2'd0;
  localparam logic [1:0] PH_SETUP  = 2'd1;
  localparam logic [1:0] PH_STROBE = 2'd2;
  localparam logic [1:0] PH_HOLD   = 2'd3;

  logic [1:0]        phase;
  logic [3:0]        cnt;       // Cycles left in phase, minus one
  logic [3:0]        wait_q;    // rd or wr wait, chosen at transfer
  logic [1:0]        hold_q;
  logic              we_q;
  logic              en_q;      // Selected bank enabled
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [CS_W-1:0]   req_bank;
  logic [NUM_CS-1:0] bank_sel;  // One-hot of latched address
  logic              xfer;
  logic              strobe_end;

  assign req_ready  = (phase == PH_IDLE);
  assign xfer       = req_valid && req_ready;
  assign strobe_end = (phase == PH_STROBE) && (cnt == 4'd0);
  assign req_bank   = req_addr[ADDR_W-1 -: CS_W];

  // --------------------------------------------------
  // Phase sequencer
  // --------------------------------------------------
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
    begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (phase)
        PH_IDLE:
        begin
          if (xfer)
          begin
            if (timing_q.tm.setup != 2'd0)
            begin
              phase <= PH_SETUP;
              cnt   <= 4'(timing_q.tm.setup) - 4'd1;
            end
            else
            begin
              phase <= PH_STROBE;  // Zero setup, straight to strobe
              cnt   <= req_we ? timing_q.tm.wr_wait : timing_q.tm.rd_wait;
            end
          end
        end
        PH_SETUP:
        begin
          if (cnt == 4'd0)
          begin
            phase <= PH_STROBE;
            cnt   <= wait_q;      // wait+1 cycles of strobe
          end
          else
            cnt <= cnt - 4'd1;
        end
        PH_STROBE:
        begin
          if (strobe_end)
          begin
            phase <= (hold_q != 2'd0) ? PH_HOLD : PH_IDLE;
            cnt   <= 4'(hold_q) - 4'd1;
          end
          else
            cnt <= cnt - 4'd1;
        end
        default:  // PH_HOLD
        begin
          if (cnt == 4'd0)
            phase <= PH_IDLE;
          else
            cnt <= cnt - 4'd1;
        end
      endcase
    end
  end

  // Access fields, frozen for the whole access
  always_ff @(posedge pclk)
  begin
    if (xfer)
    begin
      we_q    <= req_we;
      wait_q  <= req_we ? timing_q.tm.wr_wait : timing_q.tm.rd_wait;
      hold_q  <= timing_q.tm.hold;
      en_q    <= cs_ctrl_q.cs.en[req_bank];
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  // --------------------------------------------------
  // Read return
  // --------------------------------------------------
  // Sampled on last strobe cycle, pulse lands in first hold or idle cycle
  always_ff @(posedge pclk)
  begin
    if (!rst_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= strobe_end && !we_q;
  end

  always_ff @(posedge pclk)
  begin
    if (strobe_end && !we_q)
      rd_data <= en_q ? mem_rdata : '0;  // Disabled bank reads zero
  end

  // --------------------------------------------------
  // Memory strobes
  // --------------------------------------------------
  assign bank_sel  = NUM_CS'(1) << addr_q[ADDR_W-1 -: CS_W];
  assign mem_cs_n  = ~(bank_sel & {NUM_CS{(phase != PH_IDLE) && en_q}});
  assign mem_oe_n  = !((phase == PH_STROBE) && !we_q && en_q);
  assign mem_we_n  = !((phase == PH_STROBE) && we_q && en_q);
  assign mem_addr  = addr_q;   // Full address, bank bits included
  assign mem_wdata = wdata_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_oe_we_excl: assert property (
    @(posedge pclk) disable iff (!rst_n)
    !(!mem_oe_n && !mem_we_n)
  );

  a_one_cs: assert property (
    @(posedge pclk) disable iff (!rst_n)
    $onehot0(~mem_cs_n)
  );

endmodule

//--- source/smc_top.sv
// SMC top level: APB configuration slave, config registers and the two-stage host pipeline
`timescale 1ns/1ps

module smc_top
  import smc_pkg::*;
#(
  parameter int ADDR_W = 16,  // Host and memory address
  parameter int NUM_CS = 4    // Banks, power of two
)
(
  input  logic                  pclk,
  input  logic                  rst_n,
  // APB
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0]     pwdata,
  output logic [DATA_W-1:0]     prdata,
  // Host
  input  logic                  host_req,
  output logic                  host_ack,
  input  logic                  host_we,
  input  logic [ADDR_W-1:0]     host_addr,
  input  logic [DATA_W-1:0]     host_wdata,
  output logic                  rd_valid,
  output logic [DATA_W-1:0]     rd_data,
  // SRAM
  output logic [NUM_CS-1:0]     mem_cs_n,
  output logic                  mem_oe_n,
  output logic                  mem_we_n,
  output logic [ADDR_W-1:0]     mem_addr,
  output logic [DATA_W-1:0]     mem_wdata,
  input  logic [DATA_W-1:0]     mem_rdata
);

  logic              wr_timing;
  logic              wr_cs_ctrl;
  logic [DATA_W-1:0] wr_data;
  cfg_word_u         timing_q;
  cfg_word_u         cs_ctrl_q;
  // Stage link
  logic              req_valid;
  logic              req_ready;
  logic              req_we;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;

  smc_apb_if i_smc_apb_if (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .timing_q, .cs_ctrl_q, .prdata, .wr_timing, .wr_cs_ctrl, .wr_data
  );

  smc_cfg_regs #(.NUM_CS(NUM_CS)) i_smc_cfg_regs (
    .pclk, .rst_n, .wr_timing, .wr_cs_ctrl, .wr_data, .timing_q, .cs_ctrl_q
  );

  smc_req_stage #(.ADDR_W(ADDR_W)) i_smc_req_stage (
    .pclk, .rst_n, .host_req, .host_we, .host_addr, .host_wdata, .req_ready,
    .host_ack, .req_valid, .req_we, .req_addr, .req_wdata
  );

  smc_timing_stage #(.ADDR_W(ADDR_W), .NUM_CS(NUM_CS)) i_smc_timing_stage (
    .pclk, .rst_n, .req_valid, .req_we, .req_addr, .req_wdata,
    .timing_q, .cs_ctrl_q, .mem_rdata, .req_ready,
    .mem_cs_n, .mem_oe_n, .mem_we_n, .mem_addr, .mem_wdata, .rd_valid, .rd_data
  );

endmodule

//--- tb.f
source/smc_pkg.sv
source/smc_apb_if.sv
source/smc_cfg_regs.sv
source/smc_req_stage.sv
source/smc_timing_stage.sv
source/smc_top.sv
tb/sram_model.sv
tb/tb_smc.sv

//--- tb/sram_model.sv
// Behavioral SRAM banks for the SMC testbench, checking select and strobe widths per access
`timescale 1ns/1ps

module sram_model
  import smc_pkg::*;
#(
  parameter int ADDR_W = 16,
  parameter int NUM_CS = 4
)
(
  input  logic              pclk,
  input  logic [NUM_CS-1:0] cs_n,
  input  logic              oe_n,
  input  logic              we_n,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  input  logic [1:0]        exp_setup,    // Expected counts, taken as cs falls
  input  logic [3:0]        exp_rd_wait,
  input  logic [3:0]        exp_wr_wait,
  input  logic [1:0]        exp_hold,
  output logic              timing_err    // One-cycle flag per bad access
);

  localparam int CS_W = $clog2(NUM_CS);

  logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];  // All banks, full address
  logic              cs_low;
  logic [NUM_CS-1:0] cs_want;                // Select matching the address
  int                cs_cnt = 0;
  int                pre_cnt = 0;            // Setup cycles seen
  int                oe_cnt = 0;
  int                we_cnt = 0;
  int                want_setup;
  int                want_rd;
  int                want_wr;
  int                want_hold;

  assign cs_low  = (cs_n != {NUM_CS{1'b1}});
  assign cs_want = ~(NUM_CS'(1) << addr[ADDR_W-1 -: CS_W]);
  assign rdata   = (cs_low && !oe_n) ? mem[addr] : '0;  // Idle bus reads zero

  // --------------------------------------------------
  // Per-cycle sampling and width checks
  // --------------------------------------------------
  always @(posedge pclk)
  begin
    logic err;
    int   strobe_want;
    err = 1'b0;
    if (cs_low)
    begin
      if (cs_cnt == 0)
      begin
        want_setup = int'(exp_setup);  // Counts frozen for this access
        want_rd    = int'(exp_rd_wait);
        want_wr    = int'(exp_wr_wait);
        want_hold  = int'(exp_hold);
      end
      cs_cnt++;
      if (!oe_n)
        oe_cnt++;
      if (!we_n)
      begin
        we_cnt++;
        mem[addr] <= wdata;
      end
      if (oe_n && we_n && oe_cnt == 0 && we_cnt == 0)
        pre_cnt++;                      // Still in setup
      if (cs_n != cs_want)
      begin
        $display("SRAM model: chip select %b does not match address %h", cs_n, addr);
        err = 1'b1;
      end
    end
    else
    begin
      if (!oe_n || !we_n)
      begin
        $display("SRAM model: strobe went low with no chip select at %0t", $time);
        err = 1'b1;
      end
      if (cs_cnt != 0)                  // Access just ended
      begin
        strobe_want = (oe_cnt != 0) ? want_rd + 1 : want_wr + 1;
        if ((oe_cnt != 0) == (we_cnt != 0))
        begin
          $display("SRAM model: access had %0d read and %0d write strobe cycles",
                   oe_cnt, we_cnt);
          err = 1'b1;
        end
        else if (pre_cnt != want_setup || oe_cnt + we_cnt != strobe_want ||
                 cs_cnt != want_setup + strobe_want + want_hold)
        begin
          $display("SRAM model: wrong timing at %0t, setup %0d want %0d, strobe %0d want %0d,",
                   $time, pre_cnt, want_setup, oe_cnt + we_cnt, strobe_want);
          $display("SRAM model: select low %0d cycles, want %0d", cs_cnt,
                   want_setup + strobe_want + want_hold);
          err = 1'b1;
        end
        cs_cnt  = 0;
        pre_cnt = 0;
        oe_cnt  = 0;
        we_cnt  = 0;
      end
    end
    timing_err <= err;
  end

endmodule

//--- tb/tb_smc.sv
// Table-driven testbench for the SMC: APB register access and host traffic to SRAM banks
`timescale 1ns/1ps

module tb_smc
  import smc_pkg::*;
();

  localparam int          ADDR_W  = 16;
  localparam int          NUM_CS  = 4;
  localparam int          BANK_W  = $clog2(NUM_CS);
  localparam logic [31:0] TM_MASK = 32'h0000_0fff;  // setup, waits, hold
  localparam logic [31:0] CS_MASK = 32'h0000_000f;  // Four bank enables

  // Table operations
  localparam logic [2:0] OP_APB_WR  = 3'd0;
  localparam logic [2:0] OP_APB_RD  = 3'd1;
  localparam logic [2:0] OP_HOST_WR = 3'd2;
  localparam logic [2:0] OP_HOST_RD = 3'd3;  // Waits for its data
  localparam logic [2:0] OP_HOST_NB = 3'd4;  // Read issued without waiting

  typedef struct packed {
    logic [2:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] exp;   // APB reads only
  } entry_t;

  logic                  pclk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  host_req;
  logic                  host_ack;
  logic                  host_we;
  logic [ADDR_W-1:0]     host_addr;
  logic [31:0]           host_wdata;
  logic                  rd_valid;
  logic [31:0]           rd_data;
  logic [NUM_CS-1:0]     mem_cs_n;
  logic                  mem_oe_n;
  logic                  mem_we_n;
  logic [ADDR_W-1:0]     mem_addr;
  logic [31:0]           mem_wdata;
  logic [31:0]           mem_rdata;
  logic                  timing_err;

  entry_t      tbl [$];
  logic [31:0] exp_q [$];                  // Reads awaiting rd_valid
  logic [31:0] ref_mem [0:(1<<ADDR_W)-1];  // Reference memory
  logic [31:0] timing_ref;                 // Shadow of the timing register
  logic [31:0] cs_ref;                     // Shadow of the chip-select register
  logic [31:0] lcg_state;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  smc_top i_smc_top (
    .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .host_req, .host_ack, .host_we, .host_addr, .host_wdata, .rd_valid, .rd_data,
    .mem_cs_n, .mem_oe_n, .mem_we_n, .mem_addr, .mem_wdata, .mem_rdata
  );

  sram_model #(.ADDR_W(ADDR_W), .NUM_CS(NUM_CS)) i_sram_model (
    .pclk, .cs_n(mem_cs_n), .oe_n(mem_oe_n), .we_n(mem_we_n), .addr(mem_addr),
    .wdata(mem_wdata), .rdata(mem_rdata),
    .exp_setup(timing_ref[1:0]), .exp_rd_wait(timing_ref[5:2]),
    .exp_wr_wait(timing_ref[9:6]), .exp_hold(timing_ref[11:10]), .timing_err
  );

  always #50 pclk = ~pclk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp)
    begin
      fail_run($sformatf("Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                         $time, name, exp, act));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Disabled bank reads zero
  function automatic logic [31:0] expect_read(input logic [ADDR_W-1:0] addr);
    if (cs_ref[addr[ADDR_W-1 -: BANK_W]])
      return ref_mem[addr];
    return '0;
  endfunction

  // Tasks start and end on a rising edge and drive 1 ns after it
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    #1;
    psel    = 1'b1;   // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge pclk);
    #1;
    penable = 1'b1;   // Access phase
    @(posedge pclk);
    rdata = prdata;
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    @(posedge pclk);
  endtask

  // Four-phase host transfer, returns once ack is seen low again
  task automatic host_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [31:0] wdata);
    #1;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    @(posedge pclk);
    while (host_ack !== 1'b1)
      @(posedge pclk);
    #1;
    host_req = 1'b0;
    @(posedge pclk);
    while (host_ack !== 1'b0)
      @(posedge pclk);
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0] rdata;
    case (e.op)
      OP_APB_WR:
      begin
        apb_xfer(1'b1, e.addr[APB_ADDR_W-1:0], e.data, rdata);
        if (e.addr[APB_ADDR_W-1:0] == REG_TIMING)
          timing_ref = e.data & TM_MASK;     // Reserved bits drop
        else if (e.addr[APB_ADDR_W-1:0] == REG_CS_CTRL)
          cs_ref = e.data & CS_MASK;
      end
      OP_APB_RD:
      begin
        apb_xfer(1'b0, e.addr[APB_ADDR_W-1:0], 32'h0, rdata);
        compare_word("prdata", e.exp, rdata);
      end
      OP_HOST_WR:
      begin
        if (cs_ref[e.addr[ADDR_W-1 -: BANK_W]])
          ref_mem[e.addr] = e.data;          // Dropped for a disabled bank
        host_xfer(1'b1, e.addr, e.data);
      end
      default:
      begin
        exp_q.push_back(expect_read(e.addr));
        host_xfer(1'b0, e.addr, 32'h0);
        if (e.op == OP_HOST_RD)
          while (exp_q.size() != 0)
            @(posedge pclk);
      end
    endcase
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [15:0] addr,
                           input logic [31:0] data, input logic [31:0] exp);
    entry_t e;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.exp  = exp;
    tbl.push_back(e);
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  task automatic build_table();
    logic [15:0] bank_addr [4];
    bank_addr = '{16'h0010, 16'h4024, 16'h8038, 16'hc04c};  // One per bank
    // Reset values and a hole in the map
    add_entry(OP_APB_RD, 16'(REG_TIMING), 0, 32'h0000_0449);  // setup 1 rd 2 wr 1 hold 1
    add_entry(OP_APB_RD, 16'(REG_CS_CTRL), 0, 32'h0000_000f);
    add_entry(OP_APB_RD, 16'h0008, 0, 32'h0);
    // Readback with reserved bits cleared
    add_entry(OP_APB_WR, 16'(REG_TIMING), 32'habcd_e5a6, 0);
    add_entry(OP_APB_RD, 16'(REG_TIMING), 0, 32'habcd_e5a6 & TM_MASK);
    add_entry(OP_APB_WR, 16'(REG_CS_CTRL), 32'h1234_567f, 0);
    add_entry(OP_APB_RD, 16'(REG_CS_CTRL), 0, 32'h1234_567f & CS_MASK);
    add_entry(OP_APB_WR, 16'h000c, 32'hdead_beb0, 0);          // Unmapped
    add_entry(OP_APB_RD, 16'(REG_TIMING), 0, 32'h0000_05a6);
    add_entry(OP_APB_RD, 16'(REG_CS_CTRL), 0, 32'h0000_000f);
    add_entry(OP_APB_RD, 16'h000c, 0, 32'h0);
    // All four banks
    foreach (bank_addr[i])
      add_entry(OP_HOST_WR, bank_addr[i], lcg_next(), 0);
    foreach (bank_addr[i])
      add_entry(OP_HOST_RD, bank_addr[i], 0, 0);
    // Zero setup, hold 3
    add_entry(OP_APB_WR, 16'(REG_TIMING), 32'h0000_0c40, 0);
    add_entry(OP_APB_RD, 16'(REG_TIMING), 0, 32'h0000_0c40);
    add_entry(OP_HOST_WR, 16'h0100, lcg_next(), 0);
    add_entry(OP_HOST_RD, 16'h0100, 0, 0);
    // Setup 3, read wait 15, no hold
    add_entry(OP_APB_WR, 16'(REG_TIMING), 32'hffff_f03f, 0);
    add_entry(OP_HOST_WR, 16'h8100, lcg_next(), 0);
    add_entry(OP_HOST_RD, 16'h8100, 0, 0);
    // Bank 2 off, then back on
    add_entry(OP_APB_WR, 16'(REG_CS_CTRL), 32'h0000_000b, 0);
    add_entry(OP_APB_RD, 16'(REG_CS_CTRL), 0, 32'h0000_000b);
    add_entry(OP_HOST_RD, bank_addr[2], 0, 0);
    add_entry(OP_HOST_WR, bank_addr[2], lcg_next(), 0);
    add_entry(OP_HOST_RD, bank_addr[0], 0, 0);
    add_entry(OP_APB_WR, 16'(REG_CS_CTRL), 32'h0000_000f, 0);
    add_entry(OP_HOST_RD, bank_addr[2], 0, 0);
    // Back-to-back traffic, two accesses in flight
    add_entry(OP_APB_WR, 16'(REG_TIMING), 32'h0000_08d9, 0);
    foreach (bank_addr[i])
      add_entry(OP_HOST_WR, bank_addr[i] + 16'h0200, lcg_next(), 0);
    foreach (bank_addr[i])
      add_entry(OP_HOST_NB, bank_addr[i] + 16'h0200, 0, 0);
    add_entry(OP_HOST_NB, bank_addr[0], 0, 0);
    add_entry(OP_HOST_RD, bank_addr[3], 0, 0);               // Drains the queue
  endtask

  // --------------------------------------------------
  // Monitors
  // --------------------------------------------------
  always @(posedge pclk)
  begin
    if (rst_n && rd_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
        fail_run("rd_valid pulsed with no read outstanding");
      else
        compare_word("rd_data", exp_q.pop_front(), rd_data);
    end
  end

  always @(posedge pclk)
  begin
    if (timing_err === 1'b1)
      fail_run("SRAM model saw a select or strobe timing error");
  end

  always @(posedge pclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
      fail_run($sformatf("Timeout: test did not finish within %0d cycles", cycle_limit));
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    pclk       = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    cycle_cnt  = 0;
    lcg_state  = 32'hd2e8_92ff;
    timing_ref = 32'h0000_0449;
    cs_ref     = 32'h0000_000f;
    build_table();
    cycle_limit = tbl.size() * 30 + 100;  // Longest access plus handshakes
    repeat (2) @(posedge pclk);
    #1;
    rst_n = 1'b1;
    @(posedge pclk);
    // Idle outputs after reset
    compare_word("host_ack", 32'd0, {31'd0, host_ack});
    compare_word("rd_valid", 32'd0, {31'd0, rd_valid});
    compare_word("mem_cs_n", 32'h0000_000f, {28'd0, mem_cs_n});
    compare_word("mem_oe_n", 32'd1, {31'd0, mem_oe_n});
    compare_word("mem_we_n", 32'd1, {31'd0, mem_we_n});
    foreach (tbl[i])
      apply_entry(tbl[i]);
    // Wait out the last access so its width check can land
    while (mem_cs_n !== {NUM_CS{1'b1}})
      @(posedge pclk);
    repeat (2) @(posedge pclk);
    if (exp_q.size() == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
      fail_run("Reads were left without a response at the end of the test");
  end

endmodule
